// ==== flist.f ====
hdl/aud_pkg.sv
hdl/aud_frame_ctrl.sv
hdl/aud_channel_deser.sv
hdl/aud_sample_writer.sv
hdl/aud_recorder_top.sv
test/tb_aud_recorder.sv

// ==== hdl/aud_channel_deser.sv ====
`timescale 1ns/1ps

module aud_channel_deser (
	input  logic                             i_clk,
	input  logic                             i_rst_n,
	input  logic                             i_frame_start,
	input  logic                             i_capture_en,
	input  logic                             i_data,
	output logic                             o_valid,
	output logic [aud_pkg::AUD_SAMPLE_W-1:0] o_sample
);
	import aud_pkg::*;

	logic                            busy;
	logic [$clog2(AUD_SAMPLE_W)-1:0] bit_cnt;
	logic [AUD_SAMPLE_W-1:0]         shift_q;
	logic                            take_bit;

	// First bit enters with the frame start, the rest while busy.
	assign take_bit = i_capture_en && (busy || i_frame_start);

	always_ff @(posedge i_clk or posedge i_rst_n) begin
		if (i_rst_n) begin
			busy    <= 1'b0;
			bit_cnt <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			if (!i_capture_en) begin
				// Partial sample is dropped.
				busy    <= 1'b0;
				bit_cnt <= '0;
			end else if (busy) begin
				if (bit_cnt == ($clog2(AUD_SAMPLE_W))'(AUD_SAMPLE_W - 1)) begin
					busy    <= 1'b0;
					bit_cnt <= '0;
					o_valid <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else if (i_frame_start) begin
				busy    <= 1'b1;
				bit_cnt <= ($clog2(AUD_SAMPLE_W))'(1);
			end
		end
	end

	// MSB first.
	always_ff @(posedge i_clk) begin
		if (take_bit) begin
			shift_q <= {shift_q[AUD_SAMPLE_W-2:0], i_data};
		end
	end

	assign o_sample = shift_q;

	a_valid_single: assert property (
		@(posedge i_clk) disable iff (i_rst_n)
		o_valid |=> !o_valid
	);

	a_no_start_while_busy: assert property (
		@(posedge i_clk) disable iff (i_rst_n)
		busy |-> !i_frame_start
	);

endmodule

// ==== hdl/aud_frame_ctrl.sv ====
`timescale 1ns/1ps

module aud_frame_ctrl (
	input  logic                              i_clk,
	input  logic                              i_rst_n,
	input  logic                              i_lrc,
	input  logic                              i_start,
	input  logic                              i_pause,
	input  logic                              i_stop,
	input  logic                              i_full,
	output logic [aud_pkg::AUD_CHANNELS-1:0] o_frame_start,
	output logic                              o_capture_en,
	output logic                              o_clear,
	output logic                              o_recording
);
	import aud_pkg::*;

	aud_state_t state;
	aud_state_t state_next;
	logic       lrc_q;

	// Stop wins over pause, pause wins over start.
	always_comb begin
		state_next = state;
		if (i_stop) begin
			state_next = AUD_STOPPED;
		end else if ((state == AUD_RECORDING) && i_full && !o_clear) begin
			// Memory filled up.
			state_next = AUD_STOPPED;
		end else if (i_pause) begin
			if (state == AUD_RECORDING) begin
				state_next = AUD_PAUSED;
			end
		end else if (i_start) begin
			if (state != AUD_RECORDING) begin
				state_next = AUD_RECORDING;
			end
		end
	end

	always_ff @(posedge i_clk or posedge i_rst_n) begin
		if (i_rst_n) begin
			state         <= AUD_STOPPED;
			lrc_q         <= 1'b0;
			o_frame_start <= '0;
			o_clear       <= 1'b0;
		end else begin
			state <= state_next;
			lrc_q <= i_lrc;
			// Left slot follows a falling word select, right slot a rising one.
			o_frame_start[0] <= lrc_q & ~i_lrc;
			o_frame_start[1] <= ~lrc_q & i_lrc;
			// Only a fresh start from stopped wipes the memory pointer.
			o_clear <= (state == AUD_STOPPED) && (state_next == AUD_RECORDING);
		end
	end

	assign o_capture_en = (state == AUD_RECORDING);
	assign o_recording  = (state == AUD_RECORDING);

	// A clear pulse lines up with the first recording cycle after stopped.
	a_clear_on_entry: assert property (
		@(posedge i_clk) disable iff (i_rst_n)
		o_clear |-> (state == AUD_RECORDING) && ($past(state) == AUD_STOPPED)
	);

endmodule

// ==== hdl/aud_pkg.sv ====
package aud_pkg;

	// Sample and channel geometry.
	localparam int AUD_SAMPLE_W = 16;
	localparam int AUD_CHANNELS = 2;

	// Word address into the sample memory.
	localparam int AUD_ADDR_W = 20;

	// Transport state.
	typedef enum logic [1:0] {
		AUD_STOPPED   = 2'd0,
		AUD_PAUSED    = 2'd1,
		AUD_RECORDING = 2'd2
	} aud_state_t;

endpackage

// ==== hdl/aud_recorder_top.sv ====
`timescale 1ns/1ps

module aud_recorder_top #(
	parameter int unsigned P_MEM_WORDS = 2 ** aud_pkg::AUD_ADDR_W
) (
	input  logic                             i_clk,
	input  logic                             i_rst_n,
	input  logic                             i_lrc,
	input  logic                             i_data,
	input  logic                             i_start,
	input  logic                             i_pause,
	input  logic                             i_stop,
	output logic                             o_mem_we,
	output logic [aud_pkg::AUD_ADDR_W-1:0]   o_mem_addr,
	output logic [aud_pkg::AUD_SAMPLE_W-1:0] o_mem_data,
	output logic                             o_recording,
	output logic                             o_full
);
	import aud_pkg::*;

	logic [AUD_CHANNELS-1:0]                   frame_start;
	logic                                      capture_en;
	logic                                      clear;
	logic [AUD_CHANNELS-1:0]                   valid;
	logic [AUD_CHANNELS-1:0][AUD_SAMPLE_W-1:0] sample;

	aud_frame_ctrl u_frame_ctrl (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_lrc         (i_lrc),
		.i_start       (i_start),
		.i_pause       (i_pause),
		.i_stop        (i_stop),
		.i_full        (o_full),
		.o_frame_start (frame_start),
		.o_capture_en  (capture_en),
		.o_clear       (clear),
		.o_recording   (o_recording)
	);

	// One deserializer per word-select slot.
	for (genvar ch = 0; ch < AUD_CHANNELS; ch++) begin : g_chan
		aud_channel_deser u_deser (
			.i_clk         (i_clk),
			.i_rst_n       (i_rst_n),
			.i_frame_start (frame_start[ch]),
			.i_capture_en  (capture_en),
			.i_data        (i_data),
			.o_valid       (valid[ch]),
			.o_sample      (sample[ch])
		);
	end

	aud_sample_writer #(
		.P_MEM_WORDS (P_MEM_WORDS)
	) u_writer (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_clear    (clear),
		.i_valid    (valid),
		.i_sample   (sample),
		.o_mem_we   (o_mem_we),
		.o_full     (o_full),
		.o_mem_addr (o_mem_addr),
		.o_mem_data (o_mem_data)
	);

endmodule

// ==== hdl/aud_sample_writer.sv ====
`timescale 1ns/1ps

module aud_sample_writer #(
	parameter int unsigned P_MEM_WORDS = 2 ** aud_pkg::AUD_ADDR_W
) (
	input  logic                                                     i_clk,
	input  logic                                                     i_rst_n,
	input  logic                                                     i_clear,
	input  logic [aud_pkg::AUD_CHANNELS-1:0]                        i_valid,
	input  logic [aud_pkg::AUD_CHANNELS-1:0][aud_pkg::AUD_SAMPLE_W-1:0] i_sample,
	output logic                                                     o_mem_we,
	output logic                                                     o_full,
	output logic [aud_pkg::AUD_ADDR_W-1:0]                          o_mem_addr,
	output logic [aud_pkg::AUD_SAMPLE_W-1:0]                        o_mem_data
);
	import aud_pkg::*;

	logic                    any_valid;
	logic [AUD_SAMPLE_W-1:0] sel_sample;
	logic [AUD_ADDR_W-1:0]   wr_addr;
	logic                    last_word;

	// Channels never finish together, so the first hit is the only one.
	always_comb begin
		sel_sample = '0;
		for (int ch = 0; ch < AUD_CHANNELS; ch++) begin
			if (i_valid[ch]) begin
				sel_sample = i_sample[ch];
			end
		end
	end

	assign any_valid = |i_valid;
	assign last_word = (wr_addr == AUD_ADDR_W'(P_MEM_WORDS - 1));

	always_ff @(posedge i_clk or posedge i_rst_n) begin
		if (i_rst_n) begin
			o_mem_we   <= 1'b0;
			o_full     <= 1'b0;
			o_mem_addr <= '0;
			wr_addr    <= '0;
		end else begin
			o_mem_we <= 1'b0;
			if (i_clear) begin
				wr_addr <= '0;
				o_full  <= 1'b0;
			end else if (any_valid && !o_full) begin
				o_mem_we   <= 1'b1;
				o_mem_addr <= wr_addr;
				wr_addr    <= wr_addr + 1'b1;
				if (last_word) begin
					o_full <= 1'b1;
				end
			end
		end
	end

	// Write data is payload only.
	always_ff @(posedge i_clk) begin
		if (any_valid && !o_full) begin
			o_mem_data <= sel_sample;
		end
	end

	a_valid_onehot: assert property (
		@(posedge i_clk) disable iff (i_rst_n)
		$onehot0(i_valid)
	);

	a_no_write_when_full: assert property (
		@(posedge i_clk) disable iff (i_rst_n)
		o_mem_we |-> !$past(o_full)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the audio recorder testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_aud_recorder \
	-f flist.f \
	-o tb_aud_recorder

# The log decides the result, so a nonzero exit from the run is not fatal here.
./obj_dir/tb_aud_recorder > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== test/tb_aud_recorder.sv ====
`timescale 1ns/1ps

module tb_aud_recorder;
	import aud_pkg::*;

	localparam int     MEM_WORDS     = 40;
	localparam int     CLK_PERIOD    = 40;
	localparam int     HALF_FRAME    = 20;
	localparam int     FRAME_CYCLES  = 2 * HALF_FRAME;
	localparam int     RANDOM_CYCLES = 30 * FRAME_CYCLES;
	localparam int     SCRIPT_FRAMES = 84;
	localparam longint TIMEOUT_NS    = longint'(SCRIPT_FRAMES + 16) * FRAME_CYCLES * CLK_PERIOD;
	localparam int     STB_START     = 0;
	localparam int     STB_PAUSE     = 1;
	localparam int     STB_STOP      = 2;

	logic                    i_clk;
	logic                    i_rst_n;
	logic                    i_lrc;
	logic                    i_data;
	logic                    i_start;
	logic                    i_pause;
	logic                    i_stop;
	logic                    o_mem_we;
	logic [AUD_ADDR_W-1:0]   o_mem_addr;
	logic [AUD_SAMPLE_W-1:0] o_mem_data;
	logic                    o_recording;
	logic                    o_full;

	// Reference model state.
	aud_state_t              m_state;
	logic                    m_full;
	logic                    m_clear;
	logic [AUD_ADDR_W-1:0]   m_addr;
	logic                    m_lrc_prev;
	logic                    pend_live;
	int                      pend_t;
	logic [AUD_SAMPLE_W-1:0] pend_data;
	logic [AUD_SAMPLE_W-1:0] sent_q[$];
	int                      cyc;
	int                      n_writes;
	int                      n_drops;
	int                      n_full_events;
	logic                    full_prev;

	aud_recorder_top #(
		.P_MEM_WORDS (MEM_WORDS)
	) i_dut (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_lrc       (i_lrc),
		.i_data      (i_data),
		.i_start     (i_start),
		.i_pause     (i_pause),
		.i_stop      (i_stop),
		.o_mem_we    (o_mem_we),
		.o_mem_addr  (o_mem_addr),
		.o_mem_data  (o_mem_data),
		.o_recording (o_recording),
		.o_full      (o_full)
	);

	initial begin
		i_clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2);
			i_clk = ~i_clk;
		end
	end

	task automatic check_equal(input logic [31:0] expected, input logic [31:0] actual,
			input string what);
		if (actual !== expected) begin
			$display("ERROR: time %0t: %s, expected 0x%0h, got 0x%0h",
				$time, what, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "run stopped at the first mismatch");
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge i_clk);
	endtask

	task automatic pulse_strobe(input int which);
		@(posedge i_clk);
		#2;
		i_start = (which == STB_START);
		i_pause = (which == STB_PAUSE);
		i_stop  = (which == STB_STOP);
		@(posedge i_clk);
		#2;
		i_start = 1'b0;
		i_pause = 1'b0;
		i_stop  = 1'b0;
	endtask

	// Each half frame flips word select, then sends a filler bit, 16 data bits and 3 fillers.
	task automatic serial_source();
		logic [AUD_SAMPLE_W-1:0] sample;
		forever begin
			@(posedge i_clk);
			#2;
			i_lrc  = ~i_lrc;
			i_data = 1'($urandom_range(0, 1));
			sample = AUD_SAMPLE_W'($urandom);
			sent_q.push_back(sample);
			for (int b = AUD_SAMPLE_W - 1; b >= 0; b--) begin
				@(posedge i_clk);
				#2;
				i_data = sample[b];
			end
			repeat (HALF_FRAME - AUD_SAMPLE_W - 1) begin
				@(posedge i_clk);
				#2;
				i_data = 1'($urandom_range(0, 1));
			end
		end
	endtask

	task automatic reset_model();
		m_state       = AUD_STOPPED;
		m_full        = 1'b0;
		m_clear       = 1'b0;
		m_addr        = '0;
		m_lrc_prev    = 1'b0;
		pend_live     = 1'b0;
		pend_t        = 0;
		pend_data     = '0;
		cyc           = 0;
		n_writes      = 0;
		n_drops       = 0;
		n_full_events = 0;
		full_prev     = 1'b0;
	endtask

	// Advances the model by one clock edge and compares the outputs after that edge.
	task automatic predict_and_check();
		aud_state_t              nxt;
		logic                    exp_we;
		logic [AUD_ADDR_W-1:0]   exp_addr;
		logic [AUD_SAMPLE_W-1:0] exp_data;
		nxt      = m_state;
		exp_we   = 1'b0;
		exp_addr = '0;
		exp_data = '0;
		// A pending clear wins over a stale full flag.
		if (i_stop) begin
			nxt = AUD_STOPPED;
		end else if ((m_state == AUD_RECORDING) && m_full && !m_clear) begin
			nxt = AUD_STOPPED;
		end else if (i_pause) begin
			if (m_state == AUD_RECORDING) begin
				nxt = AUD_PAUSED;
			end
		end else if (i_start) begin
			if (m_state != AUD_RECORDING) begin
				nxt = AUD_RECORDING;
			end
		end
		// A surviving sample is written 17 cycles after its word-select edge.
		if (pend_live && (cyc == pend_t + 17)) begin
			pend_live = 1'b0;
			if (!m_clear && !m_full) begin
				exp_we   = 1'b1;
				exp_addr = m_addr;
				exp_data = pend_data;
			end
		end
		if (m_clear) begin
			m_addr = '0;
			m_full = 1'b0;
		end else if (exp_we) begin
			if (m_addr == AUD_ADDR_W'(MEM_WORDS - 1)) begin
				m_full = 1'b1;
			end
			m_addr = m_addr + AUD_ADDR_W'(1);
		end
		if (i_lrc != m_lrc_prev) begin
			pend_t    = cyc;
			pend_data = sent_q.pop_front();
			pend_live = 1'b1;
		end
		// Recording must hold from the edge through the LSB.
		if (pend_live && (cyc <= pend_t + 15) && (nxt != AUD_RECORDING)) begin
			pend_live = 1'b0;
			if (cyc > pend_t) begin
				n_drops++;
			end
		end
		m_clear    = (m_state == AUD_STOPPED) && (nxt == AUD_RECORDING);
		m_state    = nxt;
		m_lrc_prev = i_lrc;
		check_equal(exp_we, o_mem_we, "write strobe");
		if (exp_we) begin
			check_equal(exp_addr, o_mem_addr, "write address");
			check_equal(exp_data, o_mem_data, "write data");
		end
		if (o_mem_we) begin
			n_writes++;
		end
		check_equal(m_full, o_full, "full flag");
		check_equal(m_state == AUD_RECORDING, o_recording, "recording flag");
		if (o_full && !full_prev) begin
			n_full_events++;
		end
		full_prev = o_full;
	endtask

	// Looks just after each edge, before the next stimulus change.
	initial begin
		forever begin
			@(posedge i_clk);
			#1;
			if (i_rst_n) begin
				reset_model();
			end else begin
				cyc++;
				predict_and_check();
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the scripted frames did not complete in the expected time");
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int roll;
		int w;
		int d;
		void'($urandom(32'h3c5e_21dc));
		i_lrc     = 1'b0;
		i_data    = 1'b0;
		i_start   = 1'b0;
		i_pause   = 1'b0;
		i_stop    = 1'b0;
		i_rst_n   = 1'b1;
		repeat (3) @(posedge i_clk);
		#2;
		i_rst_n = 1'b0;
		check_equal(0, o_mem_we, "write strobe after reset");
		check_equal(0, o_full, "full flag after reset");
		check_equal(0, o_recording, "recording flag after reset");
		fork
			serial_source();
		join_none

		// Stream running while stopped.
		wait_cycles(3 * FRAME_CYCLES);
		check_equal(0, n_writes, "writes while stopped");

		pulse_strobe(STB_START);
		wait_cycles(6 * FRAME_CYCLES);
		check_equal(1, n_writes >= 10, "too few writes after start");

		// Pause in the middle of a sample, then resume.
		@(i_lrc);
		wait_cycles(8);
		d = n_drops;
		pulse_strobe(STB_PAUSE);
		w = n_writes;
		wait_cycles(2 * FRAME_CYCLES);
		check_equal(d + 1, n_drops, "sample cut by pause");
		check_equal(w, n_writes, "writes while paused");
		pulse_strobe(STB_START);
		wait_cycles(3 * FRAME_CYCLES);

		pulse_strobe(STB_STOP);
		check_equal(0, o_recording, "recording flag after stop");
		wait_cycles(2 * FRAME_CYCLES);
		pulse_strobe(STB_START);
		wait_cycles(3 * FRAME_CYCLES);

		// Fill the memory.
		w = n_full_events;
		wait_cycles(24 * FRAME_CYCLES);
		check_equal(w + 1, n_full_events, "memory full events");
		check_equal(1, o_full, "full flag once filled");
		check_equal(0, o_recording, "recording flag once filled");
		w = n_writes;
		wait_cycles(3 * FRAME_CYCLES);
		check_equal(w, n_writes, "writes while full");
		pulse_strobe(STB_START);
		wait_cycles(1);
		#2;
		check_equal(0, o_full, "full flag after new start");
		wait_cycles(2 * FRAME_CYCLES);

		// Random transport strobes.
		repeat (RANDOM_CYCLES) begin
			@(posedge i_clk);
			#2;
			roll    = $urandom_range(0, 99);
			i_start = (roll < 3);
			i_pause = (roll == 3);
			i_stop  = (roll == 4);
		end
		@(posedge i_clk);
		#2;
		i_start = 1'b0;
		i_pause = 1'b0;
		i_stop  = 1'b0;
		wait_cycles(2 * FRAME_CYCLES);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
